// ==== Bender.yml ====
package:
  name: conv1Read

sources:
  - files:
      - hdl/conv1Pkg.sv
      - hdl/scanIf.sv
      - hdl/windowScanner.sv
      - hdl/scanFifo.sv
      - hdl/tapAddrMapper.sv
      - hdl/conv1ReadCtrl.sv
  - target: simulation
    files:
      - sim/conv1Read_props.sv
      - sim/conv1ReadChecker.sv
      - sim/conv1ReadTb.sv

// ==== conv1Read.f ====
hdl/conv1Pkg.sv
hdl/scanIf.sv
hdl/windowScanner.sv
hdl/scanFifo.sv
hdl/tapAddrMapper.sv
hdl/conv1ReadCtrl.sv
sim/conv1Read_props.sv
sim/conv1ReadChecker.sv
sim/conv1ReadTb.sv

// ==== hdl/conv1Pkg.sv ====
package conv1Pkg;

    // Default frame geometry
    localparam int DefImgRows = 36;           // Image height in pixels
    localparam int DefImgCols = 28;           // Image width in pixels

    localparam int KernelSize = 3;            // Nine taps in the 3x3 window
    localparam int PoolSize = 2;              // 2x2 pooling quad

    // Region class of one pooled output position
    typedef enum logic [1:0] {
        regionInterior = 2'd0,                // Strictly inside the output grid
        regionCorner = 2'd1,                  // On both a row and a column border
        regionEdge = 2'd2                     // On exactly one border
    } regionT;

endpackage

// ==== hdl/conv1ReadCtrl.sv ====
`timescale 1ns/1ps

module conv1ReadCtrl #(
    parameter int ImgRows = conv1Pkg::DefImgRows,
    parameter int ImgCols = conv1Pkg::DefImgCols,
    parameter int Depth = 4
) (
    input logic clk,
    input logic arstN,
    input logic start,
    output logic rdReq,
    input logic rdAck,
    output logic [$clog2(ImgRows + 1)-1:0] rowAddr,
    output logic [$clog2(ImgCols + 1)-1:0] colAddr,
    output logic padTap,
    output conv1Pkg::regionT region,
    output logic frameDone
);

    scanIf #(.ImgRows(ImgRows), .ImgCols(ImgCols)) scanInIf ();
    scanIf #(.ImgRows(ImgRows), .ImgCols(ImgCols)) scanOutIf ();

    windowScanner #(
        .ImgRows(ImgRows),
        .ImgCols(ImgCols)
    ) scanner_i (
        .clk(clk),
        .arstN(arstN),
        .start(start),
        .scan(scanInIf.producer)
    );

    // Lets the scan run ahead of a slow reader
    scanFifo #(
        .ImgRows(ImgRows),
        .ImgCols(ImgCols),
        .Depth(Depth)
    ) fifo_i (
        .clk(clk),
        .arstN(arstN),
        .inPort(scanInIf.consumer),
        .outPort(scanOutIf.producer)
    );

    tapAddrMapper #(
        .ImgRows(ImgRows),
        .ImgCols(ImgCols)
    ) mapper_i (
        .clk(clk),
        .arstN(arstN),
        .start(start),
        .scan(scanOutIf.consumer),
        .rdReq(rdReq),
        .rdAck(rdAck),
        .rowAddr(rowAddr),
        .colAddr(colAddr),
        .padTap(padTap),
        .region(region),
        .frameDone(frameDone)
    );

endmodule

// ==== hdl/scanFifo.sv ====
`timescale 1ns/1ps

module scanFifo #(
    parameter int ImgRows = conv1Pkg::DefImgRows,
    parameter int ImgCols = conv1Pkg::DefImgCols,
    parameter int Depth = 4
) (
    input logic clk,
    input logic arstN,
    scanIf.consumer inPort,
    scanIf.producer outPort
);
    localparam int RowW = $clog2(ImgRows + 1);
    localparam int ColW = $clog2(ImgCols + 1);
    localparam int WordW = 1 + 4 + 2 + ColW + RowW;
    localparam int PtrW = $clog2(Depth);
    localparam int CntW = $clog2(Depth + 1);

    logic [WordW-1:0] mem [Depth];
    logic [PtrW-1:0] wrPtr;
    logic [PtrW-1:0] rdPtr;
    logic [CntW-1:0] count;
    logic push;
    logic pop;

    function automatic logic [PtrW-1:0] nextPtr(input logic [PtrW-1:0] ptr);
        return (ptr == PtrW'(Depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign push = inPort.req && !inPort.ack && count != CntW'(Depth);
    assign pop = outPort.req && outPort.ack;

    // Head slot is never written while presented
    assign {outPort.last, outPort.tap, outPort.quad, outPort.outCol, outPort.outRow} = mem[rdPtr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wrPtr] <= {inPort.last, inPort.tap, inPort.quad, inPort.outCol, inPort.outRow};
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
            inPort.ack <= 1'b0;
            outPort.req <= 1'b0;
        end else begin
            if (push) begin
                inPort.ack <= 1'b1;
                wrPtr <= nextPtr(wrPtr);
            end else if (inPort.ack && !inPort.req) begin
                inPort.ack <= 1'b0;
            end
            if (pop) begin
                outPort.req <= 1'b0;
                rdPtr <= nextPtr(rdPtr);
            end else if (!outPort.req && !outPort.ack && count != '0) begin
                outPort.req <= 1'b1;          // Present head
            end
            count <= count + CntW'(push) - CntW'(pop);
        end
    end

endmodule

// ==== hdl/scanIf.sv ====
`timescale 1ns/1ps

interface scanIf #(
    parameter int ImgRows = conv1Pkg::DefImgRows,
    parameter int ImgCols = conv1Pkg::DefImgCols
);
    localparam int RowW = $clog2(ImgRows + 1);
    localparam int ColW = $clog2(ImgCols + 1);

    logic req;                                // Four-phase request
    logic ack;                                // Four-phase acknowledge
    logic [RowW-1:0] outRow;
    logic [ColW-1:0] outCol;
    logic [1:0] quad;                         // Quad row in the high bit and quad column in the low bit
    logic [3:0] tap;                          // Kernel tap 0..8
    logic last;                               // Final tap of the frame

    modport producer (
        output req, outRow, outCol, quad, tap, last,
        input ack
    );

    modport consumer (
        input req, outRow, outCol, quad, tap, last,
        output ack
    );

endinterface

// ==== hdl/tapAddrMapper.sv ====
`timescale 1ns/1ps

module tapAddrMapper #(
    parameter int ImgRows = conv1Pkg::DefImgRows,
    parameter int ImgCols = conv1Pkg::DefImgCols
) (
    input logic clk,
    input logic arstN,
    input logic start,
    scanIf.consumer scan,
    output logic rdReq,
    input logic rdAck,
    output logic [$clog2(ImgRows + 1)-1:0] rowAddr,
    output logic [$clog2(ImgCols + 1)-1:0] colAddr,
    output logic padTap,
    output conv1Pkg::regionT region,
    output logic frameDone
);
    import conv1Pkg::*;

    localparam int RowW = $clog2(ImgRows + 1);
    localparam int ColW = $clog2(ImgCols + 1);
    localparam int GridRows = ImgRows / PoolSize;
    localparam int GridCols = ImgCols / PoolSize;

    int pixRow;
    int pixCol;
    logic padNext;
    logic rowBorder;
    logic colBorder;
    regionT regionNext;
    logic take;
    logic lastPend;                           // Current read carries the last tap
    logic ackWait;                            // Waiting for rdAck to fall

    always_comb begin
        pixRow = PoolSize * int'(scan.outRow) + int'(scan.quad[1])
               + int'(scan.tap) / KernelSize - 1;
        pixCol = PoolSize * int'(scan.outCol) + int'(scan.quad[0])
               + int'(scan.tap) % KernelSize - 1;
        padNext = pixRow < 0 || pixRow >= ImgRows || pixCol < 0 || pixCol >= ImgCols;
    end

    assign rowBorder = scan.outRow == '0 || scan.outRow == RowW'(GridRows - 1);
    assign colBorder = scan.outCol == '0 || scan.outCol == ColW'(GridCols - 1);

    always_comb begin
        if (rowBorder && colBorder) begin
            regionNext = regionCorner;
        end else if (rowBorder || colBorder) begin
            regionNext = regionEdge;
        end else begin
            regionNext = regionInterior;
        end
    end

    // New position only once the external link is idle
    assign take = scan.req && !scan.ack && !rdReq && !rdAck;

    always_ff @(posedge clk) begin
        if (take) begin
            rowAddr <= padNext ? RowW'(ImgRows) : RowW'(pixRow);  // Padding codes
            colAddr <= padNext ? ColW'(ImgCols) : ColW'(pixCol);
            padTap <= padNext;
            region <= regionNext;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            scan.ack <= 1'b0;
            rdReq <= 1'b0;
            lastPend <= 1'b0;
            ackWait <= 1'b0;
            frameDone <= 1'b0;
        end else begin
            if (take) begin
                scan.ack <= 1'b1;
                rdReq <= 1'b1;
                lastPend <= scan.last;
            end else if (scan.ack && !scan.req) begin
                scan.ack <= 1'b0;
            end
            if (rdReq && rdAck) begin
                rdReq <= 1'b0;
                ackWait <= 1'b1;
            end else if (ackWait && !rdAck) begin
                ackWait <= 1'b0;
            end
            if (start) begin
                frameDone <= 1'b0;
            end else if (ackWait && !rdAck && lastPend) begin
                frameDone <= 1'b1;            // Held until next start
            end
        end
    end

endmodule

// ==== hdl/windowScanner.sv ====
`timescale 1ns/1ps

module windowScanner #(
    parameter int ImgRows = conv1Pkg::DefImgRows,
    parameter int ImgCols = conv1Pkg::DefImgCols
) (
    input logic clk,
    input logic arstN,
    input logic start,
    scanIf.producer scan
);
    import conv1Pkg::*;

    localparam int RowW = $clog2(ImgRows + 1);
    localparam int ColW = $clog2(ImgCols + 1);
    localparam int GridRows = ImgRows / PoolSize;
    localparam int GridCols = ImgCols / PoolSize;
    localparam int TapMax = KernelSize * KernelSize - 1;
    localparam int QuadMax = PoolSize * PoolSize - 1;

    logic busy;
    logic [RowW-1:0] rowCnt;
    logic [ColW-1:0] colCnt;
    logic [1:0] quadCnt;
    logic [3:0] tapCnt;
    logic tapWrap;
    logic quadWrap;
    logic colWrap;

    assign tapWrap = tapCnt == 4'(TapMax);
    assign quadWrap = tapWrap && quadCnt == 2'(QuadMax);
    assign colWrap = quadWrap && colCnt == ColW'(GridCols - 1);

    assign scan.outRow = rowCnt;
    assign scan.outCol = colCnt;
    assign scan.quad = quadCnt;
    assign scan.tap = tapCnt;
    assign scan.last = colWrap && rowCnt == RowW'(GridRows - 1);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            busy <= 1'b0;
            scan.req <= 1'b0;
            rowCnt <= '0;
            colCnt <= '0;
            quadCnt <= '0;
            tapCnt <= '0;
        end else if (!busy) begin
            if (start) begin                  // Start ignored while busy
                busy <= 1'b1;
                scan.req <= 1'b1;
                rowCnt <= '0;
                colCnt <= '0;
                quadCnt <= '0;
                tapCnt <= '0;
            end
        end else if (scan.req) begin
            if (scan.ack) begin
                scan.req <= 1'b0;
                if (scan.last) begin
                    busy <= 1'b0;             // Frame complete
                end else if (!tapWrap) begin
                    tapCnt <= tapCnt + 1'b1;
                end else begin
                    tapCnt <= '0;
                    if (!quadWrap) begin
                        quadCnt <= quadCnt + 1'b1;
                    end else begin
                        quadCnt <= '0;
                        if (colWrap) begin
                            colCnt <= '0;
                            rowCnt <= rowCnt + 1'b1;
                        end else begin
                            colCnt <= colCnt + 1'b1;
                        end
                    end
                end
            end
        end else if (!scan.ack) begin
            scan.req <= 1'b1;                 // Previous ack has fallen
        end
    end

endmodule

// ==== sim/conv1ReadChecker.sv ====
`timescale 1ns/1ps

module conv1ReadChecker #(
    parameter int ImgRows = 8,
    parameter int ImgCols = 6
) (
    input logic clk,
    input logic arstN,
    input logic start,
    input logic rdReq,
    input logic [$clog2(ImgRows + 1)-1:0] rowAddr,
    input logic [$clog2(ImgCols + 1)-1:0] colAddr,
    input logic padTap,
    input conv1Pkg::regionT region,
    input logic frameDone,
    output int valueErrors,
    output int protocolErrors,
    output int readCount,
    output int framesDone
);
    import conv1Pkg::*;

    localparam int RowW = $clog2(ImgRows + 1);
    localparam int ColW = $clog2(ImgCols + 1);
    localparam int GridRows = ImgRows / 2;
    localparam int GridCols = ImgCols / 2;
    localparam int FrameTaps = GridRows * GridCols * 4 * 9;

    int tapIdx;                               // Running tap index within the frame
    logic started;
    logic reqPrev;
    logic donePrev;
    logic startPrev;

    // Scan order is row, column, quad, tap with the tap fastest
    function automatic void refTap(input int idx, output logic [RowW-1:0] expRow,
                                   output logic [ColW-1:0] expCol, output logic expPad,
                                   output regionT expRegion);
        int tap;
        int quad;
        int oRow;
        int oCol;
        int pixRow;
        int pixCol;
        logic rowBorder;
        logic colBorder;
        tap = idx % 9;
        quad = (idx / 9) % 4;
        oCol = (idx / 36) % GridCols;
        oRow = idx / (36 * GridCols);
        pixRow = 2 * oRow + quad / 2 + tap / 3 - 1;
        pixCol = 2 * oCol + quad % 2 + tap % 3 - 1;
        expPad = pixRow < 0 || pixRow >= ImgRows || pixCol < 0 || pixCol >= ImgCols;
        expRow = expPad ? RowW'(ImgRows) : RowW'(pixRow);
        expCol = expPad ? ColW'(ImgCols) : ColW'(pixCol);
        rowBorder = oRow == 0 || oRow == GridRows - 1;
        colBorder = oCol == 0 || oCol == GridCols - 1;
        if (rowBorder && colBorder) begin
            expRegion = regionCorner;
        end else if (rowBorder || colBorder) begin
            expRegion = regionEdge;
        end else begin
            expRegion = regionInterior;
        end
    endfunction

    task automatic reportMismatch(input string name, input int idx, input logic [31:0] expVal,
                                  input logic [31:0] actVal);
        $display("ERROR %s at tap %0d expected 0x%0h actual 0x%0h", name, idx, expVal, actVal);
        valueErrors++;
    endtask

    always @(posedge clk) begin : compareProc
        logic [RowW-1:0] expRow;
        logic [ColW-1:0] expCol;
        logic expPad;
        regionT expRegion;
        if (!arstN) begin
            valueErrors = 0;
            protocolErrors = 0;
            readCount = 0;
            framesDone = 0;
            tapIdx = 0;
            started = 1'b0;
            reqPrev = 1'b0;
            donePrev = 1'b0;
            startPrev = 1'b0;
        end else begin
            if (!started && rdReq !== 1'b0) begin
                reportMismatch("rdReq", tapIdx, 32'h0, 32'(rdReq));
            end
            if (!started && frameDone !== 1'b0) begin
                reportMismatch("frameDone", tapIdx, 32'h0, 32'(frameDone));
            end
            if (startPrev && frameDone !== 1'b0) begin   // Start clears done
                reportMismatch("frameDone", tapIdx, 32'h0, 32'(frameDone));
            end
            if (donePrev && !startPrev && frameDone !== 1'b1) begin   // Done holds until start
                reportMismatch("frameDone", tapIdx, 32'h1, 32'(frameDone));
            end
            if (start) begin
                started = 1'b1;
                tapIdx = 0;
            end
            if (rdReq && !reqPrev) begin
                if (tapIdx >= FrameTaps) begin
                    $display("Read %0d came after the frame was already complete", readCount);
                    protocolErrors++;
                end else begin
                    refTap(tapIdx, expRow, expCol, expPad, expRegion);
                    if (rowAddr !== expRow) begin
                        reportMismatch("rowAddr", tapIdx, 32'(expRow), 32'(rowAddr));
                    end
                    if (colAddr !== expCol) begin
                        reportMismatch("colAddr", tapIdx, 32'(expCol), 32'(colAddr));
                    end
                    if (padTap !== expPad) begin
                        reportMismatch("padTap", tapIdx, 32'(expPad), 32'(padTap));
                    end
                    if (region !== expRegion) begin
                        reportMismatch("region", tapIdx, 32'(expRegion), 32'(region));
                    end
                end
                tapIdx++;
                readCount++;
            end
            if (frameDone && !donePrev) begin
                framesDone++;
                if (tapIdx != FrameTaps) begin
                    $display("Frame ended after %0d reads instead of %0d", tapIdx, FrameTaps);
                    protocolErrors++;
                end
            end
            reqPrev = rdReq;
            donePrev = frameDone;
            startPrev = start;
        end
    end

endmodule

// ==== sim/conv1ReadTb.sv ====
`timescale 1ns/1ps

module conv1ReadTb;
    import conv1Pkg::*;

    localparam int ImgRows = 8;
    localparam int ImgCols = 6;
    localparam int Frames = 2;
    localparam int FrameTaps = (ImgRows / 2) * (ImgCols / 2) * 4 * 9;
    localparam int CycleLimit = Frames * FrameTaps * 16 + 200;

    logic clk;
    logic arstN;
    logic start;
    logic rdAck;
    logic rdReq;
    logic [$clog2(ImgRows + 1)-1:0] rowAddr;
    logic [$clog2(ImgCols + 1)-1:0] colAddr;
    logic padTap;
    regionT region;
    logic frameDone;
    int valueErrors;
    int protocolErrors;
    int readCount;
    int framesDone;
    int seed = 82;
    int cycles = 0;
    int delay;

    bind conv1ReadCtrl conv1Read_props #(.ImgRows(ImgRows), .ImgCols(ImgCols)) props_i (
        .clk(clk), .arstN(arstN), .rdReq(rdReq), .rdAck(rdAck), .rowAddr(rowAddr),
        .colAddr(colAddr), .padTap(padTap), .region(region)
    );

    conv1ReadCtrl #(.ImgRows(ImgRows), .ImgCols(ImgCols), .Depth(4)) dut_i (
        .clk(clk), .arstN(arstN), .start(start), .rdReq(rdReq), .rdAck(rdAck),
        .rowAddr(rowAddr), .colAddr(colAddr), .padTap(padTap), .region(region),
        .frameDone(frameDone)
    );

    conv1ReadChecker #(.ImgRows(ImgRows), .ImgCols(ImgCols)) checker_i (
        .clk(clk), .arstN(arstN), .start(start), .rdReq(rdReq), .rowAddr(rowAddr),
        .colAddr(colAddr), .padTap(padTap), .region(region), .frameDone(frameDone),
        .valueErrors(valueErrors), .protocolErrors(protocolErrors),
        .readCount(readCount), .framesDone(framesDone)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;                    // 20 ns period

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CycleLimit) begin
            $display("Timeout after %0d cycles with %0d reads done", cycles, readCount);
            $display("Test FAILED");
            $finish;
        end
    end

    // Reader side of the four-phase link with random delays
    initial begin
        rdAck = 1'b0;
        forever begin
            @(negedge clk);
            if (rdReq && !rdAck) begin
                delay = $unsigned($random(seed)) % 6;
                repeat (delay) @(negedge clk);
                rdAck = 1'b1;
                do begin
                    @(negedge clk);
                end while (rdReq);
                delay = $unsigned($random(seed)) % 6;
                repeat (delay) @(negedge clk);
                rdAck = 1'b0;
            end
        end
    end

    initial begin
        arstN = 1'b0;
        start = 1'b0;
        repeat (16) @(negedge clk);
        arstN = 1'b1;
        repeat (4) @(negedge clk);
        for (int f = 0; f < Frames; f++) begin
            start = 1'b1;
            @(negedge clk);
            start = 1'b0;
            while (!frameDone) begin
                @(negedge clk);
            end
            repeat (8) @(negedge clk);        // Done must hold until next start
        end
        $display("Closing: %0d value errors, %0d protocol errors, %0d reads, %0d frames",
                 valueErrors, protocolErrors, readCount, framesDone);
        if (valueErrors == 0 && protocolErrors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== sim/conv1Read_props.sv ====
`timescale 1ns/1ps

module conv1Read_props #(
    parameter int ImgRows = conv1Pkg::DefImgRows,
    parameter int ImgCols = conv1Pkg::DefImgCols
) (
    input logic clk,
    input logic arstN,
    input logic rdReq,
    input logic rdAck,
    input logic [$clog2(ImgRows + 1)-1:0] rowAddr,
    input logic [$clog2(ImgCols + 1)-1:0] colAddr,
    input logic padTap,
    input conv1Pkg::regionT region
);

    reqRiseIdle: assert property (@(posedge clk) disable iff (!arstN)
        $rose(rdReq) |-> !$past(rdAck))
        else $error("rdReq rose while rdAck was still high");

    // Address, flag and region hold for the whole request
    dataStable: assert property (@(posedge clk) disable iff (!arstN)
        rdReq && $past(rdReq) |-> $stable({rowAddr, colAddr, padTap, region}))
        else $error("Read outputs changed while rdReq was high");

    reqFallAcked: assert property (@(posedge clk) disable iff (!arstN)
        $fell(rdReq) |-> $past(rdAck))
        else $error("rdReq fell before rdAck rose");

endmodule
